/* logic/otp_part_pkg.sv */
// OTP partition package
// Widths, error codes, macro commands and lock encodings shared by the
// unbuffered partition, plus the decoded view of one macro read block

package otp_part_pkg;

  ////////////////////////////////////////
  // Widths
  ////////////////////////////////////////

  localparam int unsigned BlockWidth       = 64;
  localparam int unsigned WordWidth        = 32;
  localparam int unsigned OtpWidth         = 16;
  localparam int unsigned OtpByteAddrWidth = 11;
  localparam int unsigned OtpAddrShift     = 1;
  localparam int unsigned OtpAddrWidth     = 10;
  localparam int unsigned OtpSizeWidth     = 2;
  localparam int unsigned WinAddrWidth     = 9;
  localparam int unsigned ErrWidth         = 3;

  ////////////////////////////////////////
  // Error codes
  ////////////////////////////////////////

  localparam logic [ErrWidth-1:0] NoError             = 3'd0;
  localparam logic [ErrWidth-1:0] MacroError          = 3'd1;
  localparam logic [ErrWidth-1:0] MacroEccCorrError   = 3'd2;
  localparam logic [ErrWidth-1:0] MacroEccUncorrError = 3'd3;
  localparam logic [ErrWidth-1:0] AccessError         = 3'd5;
  localparam logic [ErrWidth-1:0] FsmStateError       = 3'd7;

  // Macro read commands, ECC checked or raw
  localparam logic CmdRead    = 1'b0;
  localparam logic CmdReadRaw = 1'b1;

  // Redundant lock encoding
  // Anything but LockFalse is treated as locked
  localparam logic [7:0] LockTrue  = 8'h96;
  localparam logic [7:0] LockFalse = 8'h69;

  // One macro read block
  // Seen whole as the digest, or as two bus words with the low one first
  typedef union packed {
    logic [BlockWidth-1:0]             digest;
    logic [1:0][WordWidth-1:0]         words;
  } otp_block_u;

endpackage : otp_part_pkg

/* logic/otp_part_fsm.sv */
// OTP partition control FSM
// Runs the digest read at init, serves bus reads through the macro,
// latches the error code and answers with bus errors once terminal

`timescale 1ns/1ps

module otp_part_fsm #(
  parameter bit HasDigest = 1'b1,
  parameter bit Integrity = 1'b1
) (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic                              init_req_i,
  input  logic                              escalate_en_i,
  input  logic                              tlul_req_i,
  input  logic                              addr_ok_i,
  input  logic [7:0]                        read_lock_i,
  input  logic                              otp_gnt_i,
  input  logic                              otp_rvalid_i,
  input  logic [otp_part_pkg::ErrWidth-1:0] otp_err_i,
  output logic                              init_done_o,
  output logic [otp_part_pkg::ErrWidth-1:0] error_o,
  output logic                              fsm_err_o,
  output logic                              tlul_gnt_o,
  output logic                              tlul_rvalid_o,
  output logic [1:0]                        tlul_rerror_o,
  output logic                              otp_req_o,
  output logic                              otp_cmd_o,
  output logic                              data_sel_o,
  output logic                              fwd_rdata_o,
  output logic                              digest_load_o
);

  import otp_part_pkg::*;

  ////////////////////////////////////////
  // Sparse state codes
  ////////////////////////////////////////

  localparam int unsigned StateWidth = 10;
  localparam logic [StateWidth-1:0] ResetSt    = 10'b1001011100;
  localparam logic [StateWidth-1:0] InitSt     = 10'b0110110010;
  localparam logic [StateWidth-1:0] InitWaitSt = 10'b1111000101;
  localparam logic [StateWidth-1:0] IdleSt     = 10'b0001101011;
  localparam logic [StateWidth-1:0] ReadSt     = 10'b1010100111;
  localparam logic [StateWidth-1:0] ReadWaitSt = 10'b0101011001;
  localparam logic [StateWidth-1:0] ErrorSt    = 10'b1100111010;

  logic [StateWidth-1:0] state_d, state_q;
  logic [ErrWidth-1:0]   error_d, error_q;
  logic [ErrWidth-1:0]   otp_err;
  // Set when a request was granted in the error state and still owes a response
  logic                  pend_err_d, pend_err_q;

  assign error_o   = error_q;
  assign otp_cmd_o = Integrity ? CmdRead : CmdReadRaw;

  // ECC results mean nothing without integrity, so they are masked here
  always_comb begin
    otp_err = otp_err_i;
    if (!Integrity && (otp_err_i inside {MacroEccCorrError, MacroEccUncorrError})) begin
      otp_err = NoError;
    end
  end

  always_comb begin
    state_d       = state_q;
    error_d       = error_q;
    pend_err_d    = 1'b0;
    init_done_o   = 1'b0;
    fsm_err_o     = 1'b0;
    tlul_gnt_o    = 1'b0;
    tlul_rvalid_o = 1'b0;
    tlul_rerror_o = 2'b00;
    otp_req_o     = 1'b0;
    data_sel_o    = 1'b0;
    fwd_rdata_o   = 1'b0;
    digest_load_o = 1'b0;

    case (state_q)
      // Wait for the one init request; skip the digest read if there is none
      ResetSt: begin
        if (init_req_i) begin
          state_d = HasDigest ? InitSt : IdleSt;
        end
      end
      // Digest read, held until the macro takes it
      InitSt: begin
        otp_req_o = 1'b1;
        if (otp_gnt_i) begin
          state_d = InitWaitSt;
        end
      end
      InitWaitSt: begin
        if (otp_rvalid_i) begin
          if (otp_err inside {NoError, MacroEccCorrError}) begin
            digest_load_o = 1'b1;
            state_d       = IdleSt;
            if (otp_err != NoError) begin
              error_d = MacroEccCorrError;
            end
          end else begin
            state_d = ErrorSt;
            error_d = otp_err;
          end
        end
      end
      // Grant here, soft errors are dropped with the new request
      IdleSt: begin
        init_done_o = 1'b1;
        if (tlul_req_i) begin
          tlul_gnt_o = 1'b1;
          error_d    = NoError;
          state_d    = ReadSt;
        end
      end
      // Range and lock check on the latched address
      ReadSt: begin
        init_done_o = 1'b1;
        if (addr_ok_i && (read_lock_i == LockFalse)) begin
          otp_req_o  = 1'b1;
          data_sel_o = 1'b1;
          if (otp_gnt_i) begin
            state_d = ReadWaitSt;
          end
        end else begin
          // Bus error only, partition stays usable
          tlul_rvalid_o = 1'b1;
          tlul_rerror_o = 2'b11;
          error_d       = AccessError;
          state_d       = IdleSt;
        end
      end
      ReadWaitSt: begin
        init_done_o = 1'b1;
        if (otp_rvalid_i) begin
          tlul_rvalid_o = 1'b1;
          if (otp_err inside {NoError, MacroEccCorrError}) begin
            fwd_rdata_o = 1'b1;
            state_d     = IdleSt;
            if (otp_err != NoError) begin
              error_d = MacroEccCorrError;
            end
          end else begin
            tlul_rerror_o = 2'b11;
            error_d       = otp_err;
            state_d       = ErrorSt;
          end
        end
      end
      // Terminal state, one bus error per granted request
      ErrorSt: begin
        if (error_q == NoError) begin
          error_d = FsmStateError;
        end
        if (pend_err_q) begin
          tlul_rvalid_o = 1'b1;
          tlul_rerror_o = 2'b11;
        end else if (tlul_req_i) begin
          tlul_gnt_o = 1'b1;
          pend_err_d = 1'b1;
        end
      end
      // Glitched state code
      default: begin
        state_d   = ErrorSt;
        fsm_err_o = 1'b1;
      end
    endcase

    // Escalation wins over everything above
    if (escalate_en_i) begin
      state_d   = ErrorSt;
      fsm_err_o = 1'b1;
      if (state_q != ErrorSt) begin
        error_d = FsmStateError;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= ResetSt;
      error_q    <= NoError;
      pend_err_q <= 1'b0;
    end else begin
      state_q    <= state_d;
      error_q    <= error_d;
      pend_err_q <= pend_err_d;
    end
  end

endmodule : otp_part_fsm

/* logic/otp_part_window.sv */
// OTP partition software window
// Latches the bus word address, checks it against the partition bounds and
// forms the macro address, size and forwarded read data

`timescale 1ns/1ps

module otp_part_window #(
  parameter int unsigned PartOffset = 64,
  parameter int unsigned PartSize   = 64
) (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  input  logic                                  tlul_gnt_i,
  input  logic [otp_part_pkg::WinAddrWidth-1:0] tlul_addr_i,
  input  logic                                  data_sel_i,
  input  logic                                  fwd_rdata_i,
  input  otp_part_pkg::otp_block_u              otp_rdata_i,
  output logic                                  addr_ok_o,
  output logic [otp_part_pkg::OtpAddrWidth-1:0] otp_addr_o,
  output logic [otp_part_pkg::OtpSizeWidth-1:0] otp_size_o,
  output logic [otp_part_pkg::WordWidth-1:0]    tlul_rdata_o
);

  import otp_part_pkg::*;

  // Bounds in bytes, one bit wider so the end can sit past the macro
  localparam logic [OtpByteAddrWidth:0] PartStart = (OtpByteAddrWidth+1)'(PartOffset);
  localparam logic [OtpByteAddrWidth:0] PartEnd   = (OtpByteAddrWidth+1)'(PartOffset + PartSize);
  // Digest lives in the last block of the partition
  localparam logic [OtpByteAddrWidth-1:0] DigestOffset =
      OtpByteAddrWidth'(PartOffset + PartSize - BlockWidth / 8);

  logic [WinAddrWidth-1:0]     addr_q;
  logic [OtpByteAddrWidth-1:0] byte_addr;
  logic [OtpByteAddrWidth-1:0] addr_calc;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      addr_q <= '0;
    end else if (tlul_gnt_i) begin
      addr_q <= tlul_addr_i;
    end
  end

  assign byte_addr = {addr_q, 2'b00};
  assign addr_ok_o = ({1'b0, byte_addr} >= PartStart) && ({1'b0, byte_addr} < PartEnd);

  // Macro works on 16 bit words
  assign addr_calc  = data_sel_i ? byte_addr : DigestOffset;
  assign otp_addr_o = OtpAddrWidth'(addr_calc >> OtpAddrShift);
  assign otp_size_o = data_sel_i ? OtpSizeWidth'(WordWidth / OtpWidth - 1) :
                                   OtpSizeWidth'(BlockWidth / OtpWidth - 1);

  // Only good responses carry data
  assign tlul_rdata_o = fwd_rdata_i ? otp_rdata_i.words[0] : '0;

endmodule : otp_part_window

/* logic/otp_part_digest_lock.sv */
// OTP partition digest register and lock merge
// Holds the digest read at init and registers the read and write locks,
// which also cover the uninitialized and digest-locked cases

`timescale 1ns/1ps

module otp_part_digest_lock #(
  parameter bit HasDigest         = 1'b1,
  parameter bit ReadLockByDigest  = 1'b0,
  parameter bit WriteLockByDigest = 1'b1
) (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  logic                                digest_load_i,
  input  otp_part_pkg::otp_block_u            otp_rdata_i,
  input  logic                                init_done_i,
  input  logic [7:0]                          read_lock_i,
  input  logic [7:0]                          write_lock_i,
  output logic [otp_part_pkg::BlockWidth-1:0] digest_o,
  output logic [7:0]                          read_lock_o,
  output logic [7:0]                          write_lock_o
);

  import otp_part_pkg::*;

  logic [BlockWidth-1:0] digest_q;
  logic                  digest_set;
  logic                  read_locked, write_locked;

  // Digest stays zero when the partition has none
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      digest_q <= '0;
    end else if (HasDigest && digest_load_i) begin
      digest_q <= otp_rdata_i.digest;
    end
  end

  assign digest_o   = digest_q;
  assign digest_set = (digest_q != '0);

  ////////////////////////////////////////
  // Lock merge
  ////////////////////////////////////////

  assign read_locked  = (read_lock_i != LockFalse) || !init_done_i ||
                        (ReadLockByDigest && digest_set);
  assign write_locked = (write_lock_i != LockFalse) || !init_done_i ||
                        (WriteLockByDigest && digest_set);

  // One register stage on the encoded value, locked out of reset
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      read_lock_o  <= LockTrue;
      write_lock_o <= LockTrue;
    end else begin
      read_lock_o  <= read_locked ? LockTrue : LockFalse;
      write_lock_o <= write_locked ? LockTrue : LockFalse;
    end
  end

endmodule : otp_part_digest_lock

/* logic/otp_part_unbuf.sv */
// OTP unbuffered partition
// Ties the control FSM, the software window and the digest lock block
// together between the bus port and the macro port

`timescale 1ns/1ps

module otp_part_unbuf #(
  parameter int unsigned PartOffset        = 64,
  parameter int unsigned PartSize          = 64,
  parameter bit          HasDigest         = 1'b1,
  parameter bit          Integrity         = 1'b1,
  parameter bit          ReadLockByDigest  = 1'b0,
  parameter bit          WriteLockByDigest = 1'b1
) (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  // Init and status
  input  logic                                  init_req_i,
  output logic                                  init_done_o,
  input  logic                                  escalate_en_i,
  output logic [otp_part_pkg::ErrWidth-1:0]     error_o,
  output logic                                  fsm_err_o,
  // Locks and digest
  input  logic [7:0]                            access_read_lock_i,
  input  logic [7:0]                            access_write_lock_i,
  output logic [7:0]                            access_read_lock_o,
  output logic [7:0]                            access_write_lock_o,
  output logic [otp_part_pkg::BlockWidth-1:0]   digest_o,
  // Bus side
  input  logic                                  tlul_req_i,
  output logic                                  tlul_gnt_o,
  input  logic [otp_part_pkg::WinAddrWidth-1:0] tlul_addr_i,
  output logic [1:0]                            tlul_rerror_o,
  output logic                                  tlul_rvalid_o,
  output logic [otp_part_pkg::WordWidth-1:0]    tlul_rdata_o,
  // Macro side
  output logic                                  otp_req_o,
  output logic                                  otp_cmd_o,
  output logic [otp_part_pkg::OtpSizeWidth-1:0] otp_size_o,
  output logic [otp_part_pkg::OtpAddrWidth-1:0] otp_addr_o,
  input  logic                                  otp_gnt_i,
  input  logic                                  otp_rvalid_i,
  input  otp_part_pkg::otp_block_u              otp_rdata_i,
  input  logic [otp_part_pkg::ErrWidth-1:0]     otp_err_i
);

  logic addr_ok;
  logic data_sel;
  logic fwd_rdata;
  logic digest_load;

  otp_part_fsm #(
    .HasDigest (HasDigest),
    .Integrity (Integrity)
  ) u_fsm (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .init_req_i    (init_req_i),
    .escalate_en_i (escalate_en_i),
    .tlul_req_i    (tlul_req_i),
    .addr_ok_i     (addr_ok),
    .read_lock_i   (access_read_lock_o),
    .otp_gnt_i     (otp_gnt_i),
    .otp_rvalid_i  (otp_rvalid_i),
    .otp_err_i     (otp_err_i),
    .init_done_o   (init_done_o),
    .error_o       (error_o),
    .fsm_err_o     (fsm_err_o),
    .tlul_gnt_o    (tlul_gnt_o),
    .tlul_rvalid_o (tlul_rvalid_o),
    .tlul_rerror_o (tlul_rerror_o),
    .otp_req_o     (otp_req_o),
    .otp_cmd_o     (otp_cmd_o),
    .data_sel_o    (data_sel),
    .fwd_rdata_o   (fwd_rdata),
    .digest_load_o (digest_load)
  );

  otp_part_window #(
    .PartOffset (PartOffset),
    .PartSize   (PartSize)
  ) u_window (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .tlul_gnt_i   (tlul_gnt_o),
    .tlul_addr_i  (tlul_addr_i),
    .data_sel_i   (data_sel),
    .fwd_rdata_i  (fwd_rdata),
    .otp_rdata_i  (otp_rdata_i),
    .addr_ok_o    (addr_ok),
    .otp_addr_o   (otp_addr_o),
    .otp_size_o   (otp_size_o),
    .tlul_rdata_o (tlul_rdata_o)
  );

  // Lock merge sees the same init_done that goes out of the partition
  otp_part_digest_lock #(
    .HasDigest         (HasDigest),
    .ReadLockByDigest  (ReadLockByDigest),
    .WriteLockByDigest (WriteLockByDigest)
  ) u_digest_lock (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .digest_load_i (digest_load),
    .otp_rdata_i   (otp_rdata_i),
    .init_done_i   (init_done_o),
    .read_lock_i   (access_read_lock_i),
    .write_lock_i  (access_write_lock_i),
    .digest_o      (digest_o),
    .read_lock_o   (access_read_lock_o),
    .write_lock_o  (access_write_lock_o)
  );

endmodule : otp_part_unbuf

/* testbench/otp_part_unbuf_props.sv */
// OTP partition FSM checks
// Locks while uninitialized, one response per grant, terminal state
// after an uncorrectable macro error

`timescale 1ns/1ps

module otp_part_unbuf_props #(
  parameter bit Integrity = 1'b1
) (
  input logic                              clk_i,
  input logic                              rst_ni,
  input logic                              init_done_i,
  input logic [7:0]                        read_lock_i,
  input logic                              tlul_gnt_i,
  input logic                              tlul_rvalid_i,
  input logic                              fsm_err_i,
  input logic                              otp_rvalid_i,
  input logic [otp_part_pkg::ErrWidth-1:0] otp_err_i,
  input logic [otp_part_pkg::ErrWidth-1:0] error_i
);

  import otp_part_pkg::*;

  logic        outstanding_q;
  int unsigned assert_fail_cnt = 0;

  // Open bus request, dropped on escalation since no response follows
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      outstanding_q <= 1'b0;
    end else if (tlul_gnt_i) begin
      outstanding_q <= 1'b1;
    end else if (tlul_rvalid_i || fsm_err_i) begin
      outstanding_q <= 1'b0;
    end
  end

  // Lock register reflects the uninitialized state one cycle later
  uninit_locked_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
      !init_done_i |=> (read_lock_i != LockFalse))
    else begin
      assert_fail_cnt++;
      $error("Read lock released while uninitialized");
    end

  // Each response belongs to exactly one grant
  rsp_has_gnt_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
      tlul_rvalid_i |-> outstanding_q)
    else begin
      assert_fail_cnt++;
      $error("Response without an open grant");
    end

  gnt_no_overlap_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
      tlul_gnt_i |-> !outstanding_q)
    else begin
      assert_fail_cnt++;
      $error("Grant while a response is still owed");
    end

  // Uncorrectable data ends in the terminal state
  uncorr_terminal_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
      (Integrity && otp_rvalid_i && (otp_err_i == MacroEccUncorrError)) |=>
      (fsm_err_i || (!init_done_i && (error_i != NoError))))
    else begin
      assert_fail_cnt++;
      $error("Uncorrectable error did not reach the terminal state");
    end

endmodule : otp_part_unbuf_props

/* testbench/tb_otp_part_unbuf.sv */
// Testbench for the OTP unbuffered partition
// Runs init against a macro model, a table of bus reads, then escalation
// after a fresh reset

`timescale 1ns/1ps

module tb_otp_part_unbuf;

  import otp_part_pkg::*;

  localparam int unsigned PartOffset  = 64;
  localparam int unsigned PartSize    = 64;
  localparam int unsigned ResetCycles = 8;
  localparam int unsigned InitCycles  = 20;
  localparam int unsigned NumVecs     = 11;
  localparam int unsigned NumEscVecs  = 2;
  // 40 cycles per read or lock step, plus two resets and two inits
  localparam int unsigned MaxCycles =
      40 * (NumVecs + NumEscVecs + 4) + 2 * (ResetCycles + InitCycles);
  // Digest sits in the last block of the partition
  localparam logic [OtpByteAddrWidth-1:0] DigestByteAddr =
      OtpByteAddrWidth'(PartOffset + PartSize - BlockWidth / 8);
  // Size field counts native words minus one
  localparam logic [OtpSizeWidth-1:0] BlockSize = 2'd3;
  localparam logic [OtpSizeWidth-1:0] WordSize  = 2'd1;

  typedef struct packed {
    logic [WinAddrWidth-1:0] waddr;
    logic [7:0]              rlock;
    logic [ErrWidth-1:0]     inj_err;
    logic [1:0]              exp_rerror;
    logic [WordWidth-1:0]    exp_data;
    logic [ErrWidth-1:0]     exp_error;
  } vec_t;

  logic                    clk_i;
  logic                    rst_ni;
  logic                    init_req_i;
  logic                    init_done_o;
  logic                    escalate_en_i;
  logic [ErrWidth-1:0]     error_o;
  logic                    fsm_err_o;
  logic [7:0]              access_read_lock_i;
  logic [7:0]              access_write_lock_i;
  logic [7:0]              access_read_lock_o;
  logic [7:0]              access_write_lock_o;
  logic [BlockWidth-1:0]   digest_o;
  logic                    tlul_req_i;
  logic                    tlul_gnt_o;
  logic [WinAddrWidth-1:0] tlul_addr_i;
  logic [1:0]              tlul_rerror_o;
  logic                    tlul_rvalid_o;
  logic [WordWidth-1:0]    tlul_rdata_o;
  logic                    otp_req_o;
  logic                    otp_cmd_o;
  logic [OtpSizeWidth-1:0] otp_size_o;
  logic [OtpAddrWidth-1:0] otp_addr_o;
  logic                    otp_gnt_i;
  logic                    otp_rvalid_i;
  otp_block_u              otp_rdata_i;
  logic [ErrWidth-1:0]     otp_err_i;

  vec_t                        vecs [NumVecs];
  logic [ErrWidth-1:0]         inject_err;
  logic                        digest_read_seen;
  logic [OtpByteAddrWidth-1:0] rsp_addr;
  int                          gnt_delay;
  int                          rsp_delay;
  int unsigned                 cycle_cnt = 0;

  otp_part_unbuf #(
    .PartOffset        (PartOffset),
    .PartSize          (PartSize),
    .HasDigest         (1'b1),
    .Integrity         (1'b1),
    .ReadLockByDigest  (1'b0),
    .WriteLockByDigest (1'b1)
  ) u_otp_part_unbuf (.*);

  bind otp_part_fsm otp_part_unbuf_props #(.Integrity(Integrity)) u_props (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .init_done_i   (init_done_o),
    .read_lock_i   (read_lock_i),
    .tlul_gnt_i    (tlul_gnt_o),
    .tlul_rvalid_i (tlul_rvalid_o),
    .fsm_err_i     (fsm_err_o),
    .otp_rvalid_i  (otp_rvalid_i),
    .otp_err_i     (otp_err_i),
    .error_i       (error_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  ////////////////////////////////////////
  // Reporting and compare tasks
  ////////////////////////////////////////

  task automatic fail_now(input string msg);
    $display("%s", msg);
    $display("sim failed");
    $fatal(1, "Run stopped at the first error");
  endtask

  task automatic check_word(input string name, input logic [WordWidth-1:0] got,
                            input logic [WordWidth-1:0] exp);
    if (got !== exp) fail_now($sformatf("[FAIL] %s: got 0x%08h, expected 0x%08h", name, got, exp));
  endtask

  task automatic check_error(input string name, input logic [ErrWidth-1:0] got,
                             input logic [ErrWidth-1:0] exp);
    if (got !== exp) fail_now($sformatf("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp));
  endtask

  task automatic check_lock(input string name, input logic [7:0] got, input logic [7:0] exp);
    if (got !== exp) fail_now($sformatf("[FAIL] %s: got 0x%02h, expected 0x%02h", name, got, exp));
  endtask

  task automatic check_digest(input string name, input logic [BlockWidth-1:0] got,
                              input logic [BlockWidth-1:0] exp);
    if (got !== exp) begin
      fail_now($sformatf("[FAIL] %s: got 0x%016h, expected 0x%016h", name, got, exp));
    end
  endtask

  task automatic check_size(input string name, input logic [OtpSizeWidth-1:0] got,
                            input logic [OtpSizeWidth-1:0] exp);
    if (got !== exp) fail_now($sformatf("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp));
  endtask

  task automatic check_rerror(input string name, input logic [1:0] got, input logic [1:0] exp);
    if (got !== exp) fail_now($sformatf("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp));
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) fail_now($sformatf("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp));
  endtask

  // Run length guard
  always @(posedge clk_i) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= MaxCycles) begin
      fail_now($sformatf("Timeout: no progress within %0d cycles", MaxCycles));
    end
  end

  ////////////////////////////////////////
  // Macro model
  ////////////////////////////////////////

  // Every block is a pattern of its full byte address
  function automatic otp_block_u block_pattern(input logic [OtpByteAddrWidth-1:0] byte_addr);
    otp_block_u blk;
    blk.words[0] = 32'h9e3779b9 ^ {byte_addr, 10'h2a5, byte_addr};
    blk.words[1] = 32'h6a09e667 ^ {~byte_addr, 10'h0f3, byte_addr};
    return blk;
  endfunction

  // Grant after 0 to 3 cycles, answer 1 to 4 cycles after the grant
  initial begin : macro_model
    void'($urandom(67514));
    otp_gnt_i        = 1'b0;
    otp_rvalid_i     = 1'b0;
    otp_rdata_i      = '0;
    otp_err_i        = NoError;
    digest_read_seen = 1'b0;
    rsp_addr         = '0;
    gnt_delay        = -1;
    rsp_delay        = 0;
    forever begin
      @(negedge clk_i);
      otp_gnt_i    = 1'b0;
      otp_rvalid_i = 1'b0;
      otp_rdata_i  = '0;
      otp_err_i    = NoError;
      if (rsp_delay > 0) begin
        rsp_delay = rsp_delay - 1;
        if (rsp_delay == 0) begin
          otp_rvalid_i = 1'b1;
          otp_rdata_i  = block_pattern(rsp_addr);
          otp_err_i    = inject_err;
        end
      end else if (otp_req_o) begin
        if (gnt_delay < 0) begin
          gnt_delay = int'($urandom % 4);
        end
        if (gnt_delay == 0) begin
          otp_gnt_i = 1'b1;
          rsp_addr  = {otp_addr_o, 1'b0};
          check_flag("otp_cmd_o", otp_cmd_o, CmdRead);
          if (init_done_o) begin
            // Bus reads fetch one 32 bit word
            check_size("otp_size_o", otp_size_o, WordSize);
          end else begin
            // Whole-block read of the digest during init
            check_size("otp_size_o", otp_size_o, BlockSize);
            if (rsp_addr == DigestByteAddr) begin
              digest_read_seen = 1'b1;
            end
          end
          rsp_delay = 1 + int'($urandom % 4);
          gnt_delay = -1;
        end else begin
          gnt_delay = gnt_delay - 1;
        end
      end
    end
  end

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  // Good reads return the low word of the block, errors return zero
  function automatic vec_t make_vec(input logic [WinAddrWidth-1:0] waddr,
                                    input logic [7:0] rlock, input logic [ErrWidth-1:0] inj_err,
                                    input logic good, input logic [ErrWidth-1:0] exp_error);
    vec_t       v;
    otp_block_u blk;
    blk          = block_pattern({waddr, 2'b00});
    v.waddr      = waddr;
    v.rlock      = rlock;
    v.inj_err    = inj_err;
    v.exp_rerror = good ? 2'b00 : 2'b11;
    v.exp_data   = good ? blk.words[0] : '0;
    v.exp_error  = exp_error;
    return v;
  endfunction

  task automatic apply_reset();
    @(negedge clk_i);
    rst_ni = 1'b0;
    repeat (ResetCycles) @(negedge clk_i);
    rst_ni = 1'b1;
  endtask

  task automatic run_init();
    @(negedge clk_i);
    init_req_i = 1'b1;
    @(negedge clk_i);
    init_req_i = 1'b0;
    #1;
    while (!init_done_o) begin
      @(negedge clk_i);
      #1;
    end
  endtask

  // Bus read with outputs sampled 1 ns after the falling edge
  task automatic bus_read(input vec_t v);
    @(negedge clk_i);
    access_read_lock_i = v.rlock;
    inject_err         = v.inj_err;
    tlul_addr_i        = v.waddr;
    tlul_req_i         = 1'b1;
    #1;
    while (!tlul_gnt_o) begin
      @(negedge clk_i);
      #1;
    end
    @(negedge clk_i);
    tlul_req_i = 1'b0;
    #1;
    while (!tlul_rvalid_o) begin
      @(negedge clk_i);
      #1;
    end
    check_rerror("tlul_rerror_o", tlul_rerror_o, v.exp_rerror);
    check_word("tlul_rdata_o", tlul_rdata_o, v.exp_data);
    @(negedge clk_i);
    #1;
    check_flag("tlul_rvalid_o", tlul_rvalid_o, 1'b0);
    check_error("error_o", error_o, v.exp_error);
  endtask

  initial begin : stimulus
    otp_block_u exp_blk;
    rst_ni              = 1'b0;
    init_req_i          = 1'b0;
    escalate_en_i       = 1'b0;
    access_read_lock_i  = LockFalse;
    access_write_lock_i = LockFalse;
    tlul_req_i          = 1'b0;
    tlul_addr_i         = '0;
    inject_err          = NoError;

    vecs[0]  = make_vec(9'd16, LockFalse, NoError, 1'b1, NoError);
    vecs[1]  = make_vec(9'd23, LockFalse, NoError, 1'b1, NoError);
    // Below the partition, then a good read clears the code
    vecs[2]  = make_vec(9'd8, LockFalse, NoError, 1'b0, AccessError);
    vecs[3]  = make_vec(9'd17, LockFalse, NoError, 1'b1, NoError);
    vecs[4]  = make_vec(9'd20, LockTrue, NoError, 1'b0, AccessError);
    // First word past the end
    vecs[5]  = make_vec(9'd32, LockFalse, NoError, 1'b0, AccessError);
    vecs[6]  = make_vec(9'd18, LockFalse, MacroEccCorrError, 1'b1, MacroEccCorrError);
    vecs[7]  = make_vec(9'd31, LockFalse, NoError, 1'b1, NoError);
    // Terminal from here on
    vecs[8]  = make_vec(9'd19, LockFalse, MacroEccUncorrError, 1'b0, MacroEccUncorrError);
    vecs[9]  = make_vec(9'd16, LockFalse, NoError, 1'b0, MacroEccUncorrError);
    vecs[10] = make_vec(9'd40, LockFalse, NoError, 1'b0, MacroEccUncorrError);

    apply_reset();
    #1;
    check_flag("otp_req_o", otp_req_o, 1'b0);
    check_flag("tlul_gnt_o", tlul_gnt_o, 1'b0);
    check_flag("tlul_rvalid_o", tlul_rvalid_o, 1'b0);
    check_flag("init_done_o", init_done_o, 1'b0);
    check_flag("fsm_err_o", fsm_err_o, 1'b0);
    check_error("error_o", error_o, NoError);
    check_lock("access_read_lock_o", access_read_lock_o, LockTrue);
    check_lock("access_write_lock_o", access_write_lock_o, LockTrue);

    // Init and digest
    run_init();
    exp_blk = block_pattern(DigestByteAddr);
    if (!digest_read_seen) begin
      fail_now("Init did not read the digest block from the macro");
    end
    check_digest("digest_o", digest_o, exp_blk.digest);
    check_error("error_o", error_o, NoError);
    @(negedge clk_i);
    #1;
    // Nonzero digest locks writes, reads follow the input
    check_lock("access_write_lock_o", access_write_lock_o, LockTrue);
    check_lock("access_read_lock_o", access_read_lock_o, LockFalse);
    @(negedge clk_i);
    access_read_lock_i = LockTrue;
    @(negedge clk_i);
    #1;
    check_lock("access_read_lock_o", access_read_lock_o, LockTrue);

    for (int i = 0; i < NumVecs; i++) begin
      bus_read(vecs[i]);
    end

    // Escalation after a fresh reset
    apply_reset();
    run_init();
    @(negedge clk_i);
    escalate_en_i = 1'b1;
    #1;
    check_flag("fsm_err_o", fsm_err_o, 1'b1);
    @(negedge clk_i);
    escalate_en_i = 1'b0;
    #1;
    check_flag("fsm_err_o", fsm_err_o, 1'b0);
    check_error("error_o", error_o, FsmStateError);
    bus_read(make_vec(9'd16, LockFalse, NoError, 1'b0, FsmStateError));
    bus_read(make_vec(9'd24, LockFalse, NoError, 1'b0, FsmStateError));

    if (u_otp_part_unbuf.u_fsm.u_props.assert_fail_cnt == 0) begin
      $display("sim passed");
      $finish;
    end else begin
      fail_now("Bound assertions failed during the run");
    end
  end

endmodule : tb_otp_part_unbuf

/* otp_part_unbuf.f */
logic/otp_part_pkg.sv
logic/otp_part_fsm.sv
logic/otp_part_window.sv
logic/otp_part_digest_lock.sv
logic/otp_part_unbuf.sv
testbench/otp_part_unbuf_props.sv
testbench/tb_otp_part_unbuf.sv

/* run_sim.sh */
#!/bin/sh
# Builds the OTP partition testbench with Verilator and runs it
# The simulation log decides the result

rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_otp_part_unbuf \
  -f otp_part_unbuf.f -o tb_otp_part_unbuf > sim.log 2>&1 \
  && ./obj_dir/tb_otp_part_unbuf >> sim.log 2>&1
cat sim.log
grep -q "sim failed" sim.log && { echo "FAILED"; exit 1; }
grep -q "sim passed" sim.log || { echo "FAILED"; exit 1; }
echo "PASSED"
